// File: compile.f
verilog/fifo_geom_pkg.sv
verilog/gray_code_pkg.sv
verilog/lane_ram.sv
verilog/gray_pointer.sv
verilog/fifo_occupancy.sv
verilog/fwft_read_ctrl.sv
verilog/width_down_fifo.sv
verif/fifo_checker.sv
verif/tb_width_down_fifo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the width-down FIFO testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

top=tb_width_down_fifo

verilator --binary --timing \
    --top-module "$top" \
    -f compile.f \
    -o "$top"

output=$(./obj_dir/"$top")
echo "$output"

# the run counts as passed only if the testbench printed its pass line
if grep -qxF "All tests passed!" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: verif/fifo_checker.sv
`timescale 1ns/100ps

module fifo_checker import fifo_geom_pkg::*; #(
    parameter int LANE_WIDTH = DEF_LANE_WIDTH,
    parameter int LANE_COUNT = DEF_LANE_COUNT,
    parameter int WORD_DEPTH = DEF_WORD_DEPTH,
    localparam int CNT_BITS  = count_bits(WORD_DEPTH, LANE_COUNT)
) (
    input  logic                             clock,
    input  logic                             sys_rst,
    input  logic                             wr_en,
    input  logic                             wr_ready,
    input  logic [LANE_WIDTH*LANE_COUNT-1:0] din,
    input  logic                             rd_en,
    input  logic                             valid,
    input  logic [LANE_WIDTH-1:0]            dout,
    input  logic                             full,
    input  logic [CNT_BITS-1:0]              wr_data_count,
    input  logic [CNT_BITS-1:0]              rd_data_count,
    output int                               error_count,
    output int                               lanes_compared
);

    // lanes still to come out, head of the queue is the next lane on dout
    logic [LANE_WIDTH-1:0] lanes [$];
    // valid expected after the last rising edge
    logic head_shown = 1'b0;
    int errors = 0;
    int popped = 0;

    assign error_count = errors;
    assign lanes_compared = popped;

    task automatic check_value(
        input string       name,
        input logic [63:0] got,
        input logic [63:0] exp
    );
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // falling edge: outputs have settled and inputs hold until after the next rising edge
    always @(negedge clock) begin : model_step
        int   words_held;
        logic last_lane;
        logic head_next;

        if (!sys_rst) begin
            lanes.delete();
            head_shown = 1'b0;
            check_value("valid", 64'(valid), 64'(0));
            check_value("full", 64'(full), 64'(0));
            check_value("wr_ready", 64'(wr_ready), 64'(1));
            check_value("wr_data_count", 64'(wr_data_count), 64'(0));
            check_value("rd_data_count", 64'(rd_data_count), 64'(0));
        end else begin
            // a partly read head word still occupies its slot
            words_held = (lanes.size() + LANE_COUNT - 1) / LANE_COUNT;
            check_value("wr_data_count", 64'(wr_data_count), 64'(words_held));
            check_value("rd_data_count", 64'(rd_data_count), 64'(lanes.size()));
            check_value("full", 64'(full), 64'(words_held == WORD_DEPTH));
            check_value("wr_ready", 64'(wr_ready), 64'(words_held < WORD_DEPTH));

            if (head_shown && !valid) begin
                errors++;
                $display("valid is low at %0t although a stored lane should be shown", $time);
            end else if (!head_shown) begin
                check_value("valid", 64'(valid), 64'(0));
            end

            if (valid) begin
                if (lanes.size() == 0) begin
                    errors++;
                    $display("valid is high at %0t with no lane stored", $time);
                end else begin
                    check_value("dout", 64'(dout), 64'(lanes[0]));
                end
            end

            // a stored word shows up one edge after it is first seen in the queue
            head_next = head_shown || (lanes.size() != 0);
            if (valid && rd_en && lanes.size() != 0) begin
                last_lane = (lanes.size() % LANE_COUNT) == 1;
                void'(lanes.pop_front());
                popped++;
                // word finished, valid only stays up if another word is already there
                if (last_lane) begin
                    head_next = (lanes.size() != 0);
                end
            end

            if (wr_en && wr_ready) begin
                for (int i = 0; i < LANE_COUNT; i++) begin
                    lanes.push_back(din[(LANE_COUNT-1-i)*LANE_WIDTH +: LANE_WIDTH]);
                end
            end
            head_shown = head_next;
        end
    end

endmodule

// File: verif/tb_width_down_fifo.sv
`timescale 1ns/100ps

module tb_width_down_fifo import fifo_geom_pkg::*; ();

    localparam int LANE_WIDTH     = DEF_LANE_WIDTH;
    localparam int LANE_COUNT     = DEF_LANE_COUNT;
    localparam int WORD_DEPTH     = DEF_WORD_DEPTH;
    localparam int CNT_BITS       = count_bits(WORD_DEPTH, LANE_COUNT);
    localparam int SEED           = 66653;
    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 16;
    localparam int DRIVE_DELAY    = 5;
    localparam int TIMEOUT_MARGIN = 4;
    localparam int ROW_COUNT      = 8;

    // words offered, write duty in percent, read duty in percent
    int stim_table [ROW_COUNT][3] = '{
        '{1, 100, 0},
        // sparse writes with reads held off, dout has to hold
        '{3, 25, 0},
        '{6, 30, 100},
        '{20, 100, 10},
        // fills up, the extra offers must be refused
        '{WORD_DEPTH + 4, 100, 0},
        '{40, 100, 100},
        '{30, 60, 50},
        '{30, 45, 70}
    };

    logic                             clock = 1'b0;
    logic                             sys_rst;
    logic                             wr_en;
    logic                             wr_ready;
    logic [LANE_WIDTH*LANE_COUNT-1:0] din;
    logic                             rd_en;
    logic                             valid;
    logic [LANE_WIDTH-1:0]            dout;
    logic                             full;
    logic [CNT_BITS-1:0]              wr_data_count;
    logic [CNT_BITS-1:0]              rd_data_count;
    int                               checker_errors;
    int                               checked_lanes;

    always #(CLK_PERIOD / 2) clock = ~clock;

    width_down_fifo #(
        .LANE_WIDTH    (LANE_WIDTH),
        .LANE_COUNT    (LANE_COUNT),
        .WORD_DEPTH    (WORD_DEPTH)
    ) i_dut (
        .clock         (clock),
        .sys_rst       (sys_rst),
        .wr_en         (wr_en),
        .wr_ready      (wr_ready),
        .din           (din),
        .rd_en         (rd_en),
        .valid         (valid),
        .dout          (dout),
        .full          (full),
        .wr_data_count (wr_data_count),
        .rd_data_count (rd_data_count)
    );

    fifo_checker #(
        .LANE_WIDTH     (LANE_WIDTH),
        .LANE_COUNT     (LANE_COUNT),
        .WORD_DEPTH     (WORD_DEPTH)
    ) i_checker (
        .clock          (clock),
        .sys_rst        (sys_rst),
        .wr_en          (wr_en),
        .wr_ready       (wr_ready),
        .din            (din),
        .rd_en          (rd_en),
        .valid          (valid),
        .dout           (dout),
        .full           (full),
        .wr_data_count  (wr_data_count),
        .rd_data_count  (rd_data_count),
        .error_count    (checker_errors),
        .lanes_compared (checked_lanes)
    );

    function automatic logic [LANE_WIDTH*LANE_COUNT-1:0] random_word();
        logic [LANE_WIDTH*LANE_COUNT-1:0] word;

        for (int i = 0; i < LANE_COUNT; i++) begin
            word[i*LANE_WIDTH +: LANE_WIDTH] = LANE_WIDTH'($urandom);
        end
        return word;
    endfunction

    // a refused offer is lost, it is not retried
    task automatic run_row(input int words, input int wr_duty, input int rd_duty);
        int offered;

        offered = 0;
        while (offered < words) begin
            @(posedge clock);
            #DRIVE_DELAY;
            wr_en = (int'($urandom_range(99)) < wr_duty);
            rd_en = (int'($urandom_range(99)) < rd_duty);
            din = random_word();
            if (wr_en) begin
                offered++;
            end
        end
    endtask

    task automatic drain_fifo();
        @(posedge clock);
        #DRIVE_DELAY;
        wr_en = 1'b0;
        rd_en = 1'b1;
        while (rd_data_count != '0 || valid) begin
            @(negedge clock);
        end
        @(posedge clock);
        #DRIVE_DELAY;
        rd_en = 1'b0;
        repeat (2) @(negedge clock);
    endtask

    initial begin
        void'($urandom(SEED));
        sys_rst = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        din = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        sys_rst = 1'b1;

        for (int r = 0; r < ROW_COUNT; r++) begin
            run_row(stim_table[r][0], stim_table[r][1], stim_table[r][2]);
        end
        drain_fifo();

        @(posedge clock);
        #DRIVE_DELAY;
        $display("checker: %0d lanes compared, %0d errors", checked_lanes, checker_errors);
        if (checker_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // budget grows with the lanes the table can push through
    initial begin
        int total_words;

        total_words = 0;
        for (int r = 0; r < ROW_COUNT; r++) begin
            total_words += stim_table[r][0];
        end
        #((RESET_CYCLES + total_words * LANE_COUNT * TIMEOUT_MARGIN) * CLK_PERIOD);
        $display("watchdog expired at %0t before the stimulus finished", $time);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verilog/fifo_geom_pkg.sv
package fifo_geom_pkg;

    // default geometry, overridden from the top level when needed
    parameter int DEF_LANE_WIDTH = 8;
    parameter int DEF_LANE_COUNT = 4;
    parameter int DEF_WORD_DEPTH = 16;

    // address bits of one bank, depth is a power of two
    function automatic int word_addr_bits(input int depth);
        return $clog2(depth);
    endfunction

    // bits of the lane index inside one word
    function automatic int lane_index_bits(input int lane_count);
        return $clog2(lane_count);
    endfunction

    // counts must hold the full lane total, so one value past the largest index
    function automatic int count_bits(input int depth, input int lane_count);
        return $clog2(depth * lane_count + 1);
    endfunction

endpackage

// File: verilog/fifo_occupancy.sv
`timescale 1ns/100ps

module fifo_occupancy import fifo_geom_pkg::*, gray_code_pkg::*; #(
    parameter int LANE_COUNT = DEF_LANE_COUNT,
    parameter int WORD_DEPTH = DEF_WORD_DEPTH,
    localparam int ADDR_BITS = word_addr_bits(WORD_DEPTH),
    localparam int PTR_BITS  = ADDR_BITS + 1,
    localparam int LANE_BITS = lane_index_bits(LANE_COUNT),
    localparam int CNT_BITS  = count_bits(WORD_DEPTH, LANE_COUNT)
) (
    input  logic                 clock,
    input  logic                 sys_rst,
    input  logic                 wr_en,

    // read side state
    input  logic [PTR_BITS-1:0]  rd_ptr_gray,
    input  logic [LANE_BITS-1:0] lanes_taken,

    output logic                 wr_ready,
    output logic                 full,
    output logic                 ram_wr_en,
    output logic [ADDR_BITS-1:0] wr_addr,
    output logic [CNT_BITS-1:0]  wr_data_count,
    output logic [CNT_BITS-1:0]  rd_data_count
);

    logic [PTR_BITS-1:0] wr_ptr_gray;
    logic [PTR_BITS-1:0] wr_ptr_bin;
    logic [PTR_BITS-1:0] rd_ptr_bin;
    logic [PTR_BITS-1:0] word_count;

    gray_pointer #(
        .PTR_BITS    (PTR_BITS)
    ) i_wr_ptr (
        .clock       (clock),
        .sys_rst     (sys_rst),
        .advance     (ram_wr_en),
        .gray        (wr_ptr_gray),
        .binary      (),
        .binary_next ()
    );

    assign wr_ptr_bin = PTR_BITS'(gray_to_bin(GRAY_MAX_BITS'(wr_ptr_gray)));
    assign rd_ptr_bin = PTR_BITS'(gray_to_bin(GRAY_MAX_BITS'(rd_ptr_gray)));

    // wrap bit keeps full (WORD_DEPTH) apart from empty (0) in the difference
    assign word_count = wr_ptr_bin - rd_ptr_bin;

    assign full = (word_count == PTR_BITS'(WORD_DEPTH));
    assign wr_ready = ~full;

    // writes while full are dropped here
    assign ram_wr_en = wr_en & ~full;
    assign wr_addr = wr_ptr_bin[ADDR_BITS-1:0];

    // the head word counts as held until its last lane is taken
    assign wr_data_count = CNT_BITS'(word_count);
    assign rd_data_count = CNT_BITS'(word_count * LANE_COUNT) - CNT_BITS'(lanes_taken);

endmodule

// File: verilog/fwft_read_ctrl.sv
`timescale 1ns/100ps

module fwft_read_ctrl import fifo_geom_pkg::*; #(
    parameter int LANE_WIDTH = DEF_LANE_WIDTH,
    parameter int LANE_COUNT = DEF_LANE_COUNT,
    parameter int WORD_DEPTH = DEF_WORD_DEPTH,
    localparam int ADDR_BITS = word_addr_bits(WORD_DEPTH),
    localparam int PTR_BITS  = ADDR_BITS + 1,
    localparam int LANE_BITS = lane_index_bits(LANE_COUNT),
    localparam int CNT_BITS  = count_bits(WORD_DEPTH, LANE_COUNT)
) (
    input  logic                             clock,
    input  logic                             sys_rst,
    input  logic                             rd_en,

    // words held, head word included
    input  logic [CNT_BITS-1:0]              wr_data_count,

    // bank outputs, bank 0 in the top lane
    input  logic [LANE_WIDTH*LANE_COUNT-1:0] ram_rd_data,
    output logic                             ram_rd_en,
    output logic [ADDR_BITS-1:0]             rd_addr,

    output logic [PTR_BITS-1:0]              rd_ptr_gray,
    output logic [LANE_BITS-1:0]             lanes_taken,

    output logic                             valid,
    output logic [LANE_WIDTH-1:0]            dout
);

    logic                  head_loaded;
    logic [LANE_COUNT-1:0] lane_sel;
    logic [PTR_BITS-1:0]   rd_ptr_bin;
    logic [PTR_BITS-1:0]   rd_ptr_bin_next;
    logic                  word_stored;
    logic                  next_stored;
    logic                  prefetch;
    logic                  take_lane;
    logic                  word_done;
    logic                  fetch_next;

    // points at the head word, advances once its last lane is gone
    gray_pointer #(
        .PTR_BITS    (PTR_BITS)
    ) i_rd_ptr (
        .clock       (clock),
        .sys_rst     (sys_rst),
        .advance     (word_done),
        .gray        (rd_ptr_gray),
        .binary      (rd_ptr_bin),
        .binary_next (rd_ptr_bin_next)
    );

    assign word_stored = (wr_data_count != '0);
    assign next_stored = (wr_data_count > CNT_BITS'(1));

    // nothing on the banks' outputs yet but a word sits at the pointer
    assign prefetch = ~head_loaded & word_stored;

    assign take_lane = head_loaded & rd_en;
    assign word_done = take_lane & lane_sel[LANE_COUNT-1];

    // chain straight into the following word so the stream has no bubble
    assign fetch_next = word_done & next_stored;

    assign ram_rd_en = prefetch | fetch_next;
    assign rd_addr = prefetch ? rd_ptr_bin[ADDR_BITS-1:0] : rd_ptr_bin_next[ADDR_BITS-1:0];

    assign valid = head_loaded;

    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            head_loaded <= 1'b0;
        end else if (prefetch) begin
            head_loaded <= 1'b1;
        end else if (word_done && !next_stored) begin
            head_loaded <= 1'b0;
        end
    end

    // one-hot select, rotates back to bank 0 after the last lane
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            lane_sel <= LANE_COUNT'(1);
        end else if (take_lane) begin
            lane_sel <= {lane_sel[LANE_COUNT-2:0], lane_sel[LANE_COUNT-1]};
        end
    end

    // encode the select and pick that bank's lane
    always_comb begin
        lanes_taken = '0;
        dout = '0;
        for (int i = 0; i < LANE_COUNT; i++) begin
            if (lane_sel[i]) begin
                lanes_taken = LANE_BITS'(i);
                dout = ram_rd_data[(LANE_COUNT-1-i)*LANE_WIDTH +: LANE_WIDTH];
            end
        end
    end

endmodule

// File: verilog/gray_code_pkg.sv
package gray_code_pkg;

    // widest pointer the conversions handle
    parameter int GRAY_MAX_BITS = 32;

    // upper unused bits come in as zero and drop out of the result
    function automatic logic [GRAY_MAX_BITS-1:0] gray_to_bin(
        input logic [GRAY_MAX_BITS-1:0] gray
    );
        logic [GRAY_MAX_BITS-1:0] bin;

        bin[GRAY_MAX_BITS-1] = gray[GRAY_MAX_BITS-1];
        // each binary bit folds in every gray bit above it
        for (int i = GRAY_MAX_BITS - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    function automatic logic [GRAY_MAX_BITS-1:0] bin_to_gray(
        input logic [GRAY_MAX_BITS-1:0] bin
    );
        return bin ^ (bin >> 1);
    endfunction

endpackage

// File: verilog/gray_pointer.sv
`timescale 1ns/100ps

module gray_pointer import gray_code_pkg::*; #(
    parameter int PTR_BITS = 5
) (
    input  logic                clock,
    input  logic                sys_rst,
    input  logic                advance,
    output logic [PTR_BITS-1:0] gray,
    output logic [PTR_BITS-1:0] binary,
    output logic [PTR_BITS-1:0] binary_next
);

    logic [PTR_BITS-1:0] gray_q;

    // msb is the wrap bit, the rest addresses the banks
    assign gray = gray_q;
    assign binary = PTR_BITS'(gray_to_bin(GRAY_MAX_BITS'(gray_q)));
    assign binary_next = binary + PTR_BITS'(1);

    // step one gray code per advance, only a single bit toggles
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            gray_q <= '0;
        end else if (advance) begin
            gray_q <= PTR_BITS'(bin_to_gray(GRAY_MAX_BITS'(binary_next)));
        end
    end

endmodule

// File: verilog/lane_ram.sv
`timescale 1ns/100ps

module lane_ram import fifo_geom_pkg::*; #(
    parameter int LANE_WIDTH = DEF_LANE_WIDTH,
    parameter int WORD_DEPTH = DEF_WORD_DEPTH,
    localparam int ADDR_BITS = word_addr_bits(WORD_DEPTH)
) (
    input  logic                  clock,

    // write port
    input  logic                  wr_en,
    input  logic [ADDR_BITS-1:0]  wr_addr,
    input  logic [LANE_WIDTH-1:0] wr_data,

    // read port
    input  logic                  rd_en,
    input  logic [ADDR_BITS-1:0]  rd_addr,
    output logic [LANE_WIDTH-1:0] rd_data
);

    // one lane of every stored word
    logic [LANE_WIDTH-1:0] mem [WORD_DEPTH];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, output keeps the last word while rd_en is low
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: verilog/width_down_fifo.sv
`timescale 1ns/100ps

module width_down_fifo import fifo_geom_pkg::*; #(
    parameter int LANE_WIDTH = DEF_LANE_WIDTH,
    parameter int LANE_COUNT = DEF_LANE_COUNT,
    parameter int WORD_DEPTH = DEF_WORD_DEPTH,
    localparam int ADDR_BITS = word_addr_bits(WORD_DEPTH),
    localparam int LANE_BITS = lane_index_bits(LANE_COUNT),
    localparam int CNT_BITS  = count_bits(WORD_DEPTH, LANE_COUNT)
) (
    input  logic                             clock,
    input  logic                             sys_rst,

    // write side, one wide word per accepted write
    input  logic                             wr_en,
    output logic                             wr_ready,
    input  logic [LANE_WIDTH*LANE_COUNT-1:0] din,

    // read side, one lane per consumed read
    input  logic                             rd_en,
    output logic                             valid,
    output logic [LANE_WIDTH-1:0]            dout,

    output logic                             full,
    output logic [CNT_BITS-1:0]              wr_data_count,
    output logic [CNT_BITS-1:0]              rd_data_count
);

    logic                             ram_wr_en;
    logic [ADDR_BITS-1:0]             wr_addr;
    logic                             ram_rd_en;
    logic [ADDR_BITS-1:0]             rd_addr;
    logic [LANE_WIDTH*LANE_COUNT-1:0] ram_rd_data;
    logic [ADDR_BITS:0]               rd_ptr_gray;
    logic [LANE_BITS-1:0]             lanes_taken;

    fifo_occupancy #(
        .LANE_COUNT    (LANE_COUNT),
        .WORD_DEPTH    (WORD_DEPTH)
    ) i_occupancy (
        .clock         (clock),
        .sys_rst       (sys_rst),
        .wr_en         (wr_en),
        .rd_ptr_gray   (rd_ptr_gray),
        .lanes_taken   (lanes_taken),
        .wr_ready      (wr_ready),
        .full          (full),
        .ram_wr_en     (ram_wr_en),
        .wr_addr       (wr_addr),
        .wr_data_count (wr_data_count),
        .rd_data_count (rd_data_count)
    );

    fwft_read_ctrl #(
        .LANE_WIDTH    (LANE_WIDTH),
        .LANE_COUNT    (LANE_COUNT),
        .WORD_DEPTH    (WORD_DEPTH)
    ) i_read_ctrl (
        .clock         (clock),
        .sys_rst       (sys_rst),
        .rd_en         (rd_en),
        .wr_data_count (wr_data_count),
        .ram_rd_data   (ram_rd_data),
        .ram_rd_en     (ram_rd_en),
        .rd_addr       (rd_addr),
        .rd_ptr_gray   (rd_ptr_gray),
        .lanes_taken   (lanes_taken),
        .valid         (valid),
        .dout          (dout)
    );

    // bank i takes lane i counted from the msb end of din
    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_bank
        lane_ram #(
            .LANE_WIDTH (LANE_WIDTH),
            .WORD_DEPTH (WORD_DEPTH)
        ) i_bank (
            .clock      (clock),
            .wr_en      (ram_wr_en),
            .wr_addr    (wr_addr),
            .wr_data    (din[(LANE_COUNT-1-i)*LANE_WIDTH +: LANE_WIDTH]),
            .rd_en      (ram_rd_en),
            .rd_addr    (rd_addr),
            .rd_data    (ram_rd_data[(LANE_COUNT-1-i)*LANE_WIDTH +: LANE_WIDTH])
        );
    end

endmodule
